// File: design/clint_timer.sv
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
    input  logic    sys_clk,
    input  logic    sys_rst,
    wb_bus_if.slave bus,
    output logic    timer_irq_o   // Machine timer interrupt
);
    import soc_bus_pkg::*;

    clint_time_t            mtime_q;
    clint_time_t            mtimecmp_q;
    clint_time_t            mtime_nxt;
    clint_time_t            mtimecmp_nxt;
    logic                   req;
    logic                   hit_mtime;
    logic                   hit_cmp;
    logic                   hi_word;
    logic [CLINT_OFS_W-1:0] ofs;
    logic [DATA_W-1:0]      rd_data;

    // Byte-wise merge of a bus write into a stored word
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_w,
        input logic [DATA_W-1:0] new_w,
        input logic [SEL_W-1:0]  sel
    );
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int i = 0; i < SEL_W; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign req       = bus.cyc && bus.stb && !bus.ack;  // No second ack for a held stb
    assign ofs       = bus.adr[CLINT_OFS_W-1:0];
    assign hit_mtime = ofs[CLINT_OFS_W-1:3] == MTIME_OFS[CLINT_OFS_W-1:3];
    assign hit_cmp   = ofs[CLINT_OFS_W-1:3] == MTIMECMP_OFS[CLINT_OFS_W-1:3];
    assign hi_word   = ofs[2];

    // Next timer values, a bus write replaces the increment
    always_comb begin
        mtime_nxt.count = mtime_q.count + 64'd1;
        mtimecmp_nxt    = mtimecmp_q;
        if (req && bus.we) begin
            if (hit_mtime) begin
                mtime_nxt = mtime_q;
                if (hi_word) begin
                    mtime_nxt.half.hi = merge_bytes(mtime_q.half.hi, bus.dat_w, bus.sel);
                end else begin
                    mtime_nxt.half.lo = merge_bytes(mtime_q.half.lo, bus.dat_w, bus.sel);
                end
            end
            if (hit_cmp) begin
                if (hi_word) begin
                    mtimecmp_nxt.half.hi = merge_bytes(mtimecmp_q.half.hi, bus.dat_w, bus.sel);
                end else begin
                    mtimecmp_nxt.half.lo = merge_bytes(mtimecmp_q.half.lo, bus.dat_w, bus.sel);
                end
            end
        end
    end

    // Read mux, other offsets read 0
    always_comb begin
        rd_data = '0;
        if (hit_mtime) begin
            rd_data = hi_word ? mtime_q.half.hi : mtime_q.half.lo;
        end else if (hit_cmp) begin
            rd_data = hi_word ? mtimecmp_q.half.hi : mtimecmp_q.half.lo;
        end
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            mtime_q.count    <= '0;
            mtimecmp_q.count <= '1;  // Far future, no irq
            bus.ack          <= 1'b0;
            timer_irq_o      <= 1'b0;
        end else begin
            mtime_q     <= mtime_nxt;
            mtimecmp_q  <= mtimecmp_nxt;
            bus.ack     <= req;
            timer_irq_o <= mtime_q.count >= mtimecmp_q.count;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (req) begin
            bus.dat_r <= rd_data;
        end
    end

    assign bus.err = 1'b0;

endmodule

`default_nettype wire

// File: design/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // Bus widths
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int SEL_W       = DATA_W / 8;  // One select per byte
    localparam int SRAM_ADDR_W = 20;          // Word address on the chip

    // Address map
    localparam logic [ADDR_W-1:0] SRAM_BASE  = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] SRAM_MASK  = 32'hFFC0_0000;  // 4 MB
    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] CLINT_MASK = 32'hFFF0_0000;

    // Timer register offsets inside the CLINT window
    localparam int CLINT_OFS_W = 20;
    localparam logic [CLINT_OFS_W-1:0] MTIMECMP_OFS = 20'h0_4000;  // Hi word at +4
    localparam logic [CLINT_OFS_W-1:0] MTIME_OFS    = 20'h0_BFF8;  // Hi word at +4

    // Target of the current transfer
    typedef enum logic [1:0] {
        SLV_SRAM,
        SLV_CLINT,
        SLV_NONE
    } slave_sel_t;

    // 64-bit timer word, seen as one count or as two bus words
    typedef union packed {
        logic [63:0] count;      // Increment and compare
        struct packed {
            logic [DATA_W-1:0] hi;
            logic [DATA_W-1:0] lo;
        } half;                  // Bus access
    } clint_time_t;

endpackage

`default_nettype wire

// File: design/soc_bus_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_bus_top (
    input  logic                                sys_clk,
    input  logic                                sys_rst,

    // Instruction fetch master
    input  logic [soc_bus_pkg::ADDR_W-1:0]      inst_adr_i,
    input  logic                                inst_cyc_i,
    input  logic                                inst_stb_i,
    output logic [soc_bus_pkg::DATA_W-1:0]      inst_dat_o,
    output logic                                inst_ack_o,
    output logic                                inst_err_o,

    // Data master
    input  logic [soc_bus_pkg::ADDR_W-1:0]      data_adr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]      data_dat_i,
    input  logic                                data_we_i,
    input  logic [soc_bus_pkg::SEL_W-1:0]       data_sel_i,
    input  logic                                data_cyc_i,
    input  logic                                data_stb_i,
    output logic [soc_bus_pkg::DATA_W-1:0]      data_dat_o,
    output logic                                data_ack_o,
    output logic                                data_err_o,

    // Base SRAM chip
    output logic [soc_bus_pkg::SRAM_ADDR_W-1:0] sram_addr_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]      sram_data_i,
    output logic [soc_bus_pkg::DATA_W-1:0]      sram_data_o,
    output logic                                sram_data_oe_o,
    output logic                                sram_ce_n_o,
    output logic                                sram_oe_n_o,
    output logic                                sram_we_n_o,
    output logic [soc_bus_pkg::SEL_W-1:0]       sram_be_n_o,

    output logic                                timer_irq_o
);

    wb_bus_if fetch_bus ();  // Fetch port into the arbiter
    wb_bus_if data_bus ();   // Data port into the arbiter
    wb_bus_if m_bus ();      // Arbiter to decoder
    wb_bus_if sram_bus ();
    wb_bus_if clint_bus ();

    // Fetch only reads whole words
    assign fetch_bus.adr   = inst_adr_i;
    assign fetch_bus.dat_w = '0;
    assign fetch_bus.we    = 1'b0;
    assign fetch_bus.sel   = '1;
    assign fetch_bus.cyc   = inst_cyc_i;
    assign fetch_bus.stb   = inst_stb_i;
    assign inst_dat_o      = fetch_bus.dat_r;
    assign inst_ack_o      = fetch_bus.ack;
    assign inst_err_o      = fetch_bus.err;

    assign data_bus.adr    = data_adr_i;
    assign data_bus.dat_w  = data_dat_i;
    assign data_bus.we     = data_we_i;
    assign data_bus.sel    = data_sel_i;
    assign data_bus.cyc    = data_cyc_i;
    assign data_bus.stb    = data_stb_i;
    assign data_dat_o      = data_bus.dat_r;
    assign data_ack_o      = data_bus.ack;
    assign data_err_o      = data_bus.err;

    wb_arbiter u_arbiter (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .fetch   (fetch_bus),
        .data    (data_bus),
        .bus     (m_bus)
    );

    wb_decoder u_decoder (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .bus     (m_bus),
        .sram    (sram_bus),
        .clint   (clint_bus)
    );

    sram_controller u_sram (
        .sys_clk        (sys_clk),
        .sys_rst        (sys_rst),
        .bus            (sram_bus),
        .sram_addr_o    (sram_addr_o),
        .sram_data_i    (sram_data_i),
        .sram_data_o    (sram_data_o),
        .sram_data_oe_o (sram_data_oe_o),
        .sram_ce_n_o    (sram_ce_n_o),
        .sram_oe_n_o    (sram_oe_n_o),
        .sram_we_n_o    (sram_we_n_o),
        .sram_be_n_o    (sram_be_n_o)
    );

    clint_timer u_clint (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .bus         (clint_bus),
        .timer_irq_o (timer_irq_o)
    );

endmodule

`default_nettype wire

// File: design/sram_controller.sv
`timescale 1ns/10ps
`default_nettype none

module sram_controller (
    input  logic                               sys_clk,
    input  logic                               sys_rst,
    wb_bus_if.slave                            bus,
    output logic [soc_bus_pkg::SRAM_ADDR_W-1:0] sram_addr_o,     // Word address
    input  logic [soc_bus_pkg::DATA_W-1:0]      sram_data_i,     // Chip to controller
    output logic [soc_bus_pkg::DATA_W-1:0]      sram_data_o,     // Controller to chip
    output logic                               sram_data_oe_o,  // Drive data pins
    output logic                               sram_ce_n_o,
    output logic                               sram_oe_n_o,
    output logic                               sram_we_n_o,
    output logic [soc_bus_pkg::SEL_W-1:0]       sram_be_n_o
);
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,  // Chip strobes active
        ST_DONE     // Ack cycle
    } state_t;

    state_t state_q;
    logic   start;

    assign start = (state_q == ST_IDLE) && bus.cyc && bus.stb;

    // Control state and chip strobes
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            state_q        <= ST_IDLE;
            sram_ce_n_o    <= 1'b1;
            sram_oe_n_o    <= 1'b1;
            sram_we_n_o    <= 1'b1;
            sram_data_oe_o <= 1'b0;
            bus.ack        <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q        <= ST_ACCESS;
                        sram_ce_n_o    <= 1'b0;
                        sram_oe_n_o    <= bus.we;   // Low for a read
                        sram_we_n_o    <= !bus.we;  // Low for a write
                        sram_data_oe_o <= bus.we;
                    end
                end
                ST_ACCESS: begin
                    state_q        <= ST_DONE;
                    sram_ce_n_o    <= 1'b1;  // Release, we_n edge stores the write
                    sram_oe_n_o    <= 1'b1;
                    sram_we_n_o    <= 1'b1;
                    sram_data_oe_o <= 1'b0;
                    bus.ack        <= 1'b1;
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                    bus.ack <= 1'b0;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Address, byte enables and write data held through the access
    always_ff @(posedge sys_clk) begin
        if (start) begin
            sram_addr_o <= bus.adr[SRAM_ADDR_W+1:2];
            sram_be_n_o <= ~bus.sel;
            sram_data_o <= bus.dat_w;
        end
        if (state_q == ST_ACCESS && !bus.we) begin
            bus.dat_r <= sram_data_i;  // Read data sampled at end of access
        end
    end

    assign bus.err = 1'b0;  // Every SRAM access completes

endmodule

`default_nettype wire

// File: design/wb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
    input  logic    sys_clk,
    input  logic    sys_rst,
    wb_bus_if.slave fetch,   // Instruction port, read only
    wb_bus_if.slave data,    // Load/store port
    wb_bus_if.master bus     // Shared bus to the decoder
);

    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_FETCH,
        OWN_DATA
    } owner_t;

    owner_t owner_q;  // Bus owner held across a transfer
    owner_t grant;    // Owner in this cycle
    logic   fetch_req;
    logic   data_req;

    assign fetch_req = fetch.cyc && fetch.stb;
    assign data_req  = data.cyc && data.stb;

    // Data port wins a tie in an idle cycle
    always_comb begin
        grant = owner_q;
        if (owner_q == OWN_IDLE) begin
            if (data_req) begin
                grant = OWN_DATA;
            end else if (fetch_req) begin
                grant = OWN_FETCH;
            end
        end
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            owner_q <= OWN_IDLE;
        end else if (bus.ack || bus.err || !bus.cyc) begin
            owner_q <= OWN_IDLE;  // Transfer over, other master may win next
        end else begin
            owner_q <= grant;
        end
    end

    // Request path, combinational
    always_comb begin
        if (grant == OWN_FETCH) begin
            bus.adr   = fetch.adr;
            bus.dat_w = fetch.dat_w;
            bus.we    = fetch.we;
            bus.sel   = fetch.sel;
        end else begin
            bus.adr   = data.adr;
            bus.dat_w = data.dat_w;
            bus.we    = data.we;
            bus.sel   = data.sel;
        end
    end

    assign bus.cyc = (grant == OWN_FETCH) ? fetch.cyc
                   : (grant == OWN_DATA)  ? data.cyc : 1'b0;
    assign bus.stb = (grant == OWN_FETCH) ? fetch.stb
                   : (grant == OWN_DATA)  ? data.stb : 1'b0;

    // Response goes back to the owner alone
    assign fetch.dat_r = bus.dat_r;
    assign data.dat_r  = bus.dat_r;
    assign fetch.ack   = bus.ack && (grant == OWN_FETCH);
    assign fetch.err   = bus.err && (grant == OWN_FETCH);
    assign data.ack    = bus.ack && (grant == OWN_DATA);
    assign data.err    = bus.err && (grant == OWN_DATA);

endmodule

`default_nettype wire

// File: design/wb_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// Classic single-transfer Wishbone link
interface wb_bus_if;
    import soc_bus_pkg::*;

    logic [ADDR_W-1:0] adr;    // Byte address
    logic [DATA_W-1:0] dat_w;  // Master to slave
    logic [DATA_W-1:0] dat_r;  // Slave to master, valid with ack
    logic              we;
    logic [SEL_W-1:0]  sel;    // Byte selects
    logic              cyc;
    logic              stb;
    logic              ack;    // One cycle per request
    logic              err;    // Never together with ack

    modport master (
        output adr, dat_w, we, sel, cyc, stb,
        input  dat_r, ack, err
    );

    modport slave (
        input  adr, dat_w, we, sel, cyc, stb,
        output dat_r, ack, err
    );

endinterface

`default_nettype wire

// File: design/wb_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module wb_decoder (
    input  logic     sys_clk,
    input  logic     sys_rst,
    wb_bus_if.slave  bus,    // From the arbiter
    wb_bus_if.master sram,   // SRAM controller
    wb_bus_if.master clint   // Core-local timer
);
    import soc_bus_pkg::*;

    slave_sel_t slv;    // Target picked from the address
    logic       req;
    logic       err_q;  // Error answer for unmapped addresses

    // Address windows
    always_comb begin
        if ((bus.adr & SRAM_MASK) == SRAM_BASE) begin
            slv = SLV_SRAM;
        end else if ((bus.adr & CLINT_MASK) == CLINT_BASE) begin
            slv = SLV_CLINT;
        end else begin
            slv = SLV_NONE;
        end
    end

    assign req = bus.cyc && bus.stb;

    // Request fields go to both slaves, strobes only to the selected one
    assign sram.adr    = bus.adr;
    assign sram.dat_w  = bus.dat_w;
    assign sram.we     = bus.we;
    assign sram.sel    = bus.sel;
    assign sram.cyc    = bus.cyc && (slv == SLV_SRAM);
    assign sram.stb    = req && (slv == SLV_SRAM);

    assign clint.adr   = bus.adr;
    assign clint.dat_w = bus.dat_w;
    assign clint.we    = bus.we;
    assign clint.sel   = bus.sel;
    assign clint.cyc   = bus.cyc && (slv == SLV_CLINT);
    assign clint.stb   = req && (slv == SLV_CLINT);

    // One err pulse, cleared by itself while stb is still up
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req && (slv == SLV_NONE) && !err_q;
        end
    end

    // Response mux, address is held until the answer
    always_comb begin
        case (slv)
            SLV_SRAM: begin
                bus.dat_r = sram.dat_r;
                bus.ack   = sram.ack;
                bus.err   = sram.err;
            end
            SLV_CLINT: begin
                bus.dat_r = clint.dat_r;
                bus.ack   = clint.ack;
                bus.err   = clint.err;
            end
            default: begin
                bus.dat_r = '0;
                bus.ack   = 1'b0;
                bus.err   = err_q;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_soc_bus \
    --Mdir obj_dir \
    -o tb_soc_bus_sim

# An assertion may stop the run early, the log decides
./obj_dir/tb_soc_bus_sim 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run passed"

// File: sources.f
design/soc_bus_pkg.sv
design/wb_bus_if.sv
design/wb_arbiter.sv
design/wb_decoder.sv
design/sram_controller.sv
design/clint_timer.sv
design/soc_bus_top.sv
testbench/soc_bus_assertions.sv
testbench/tb_soc_bus.sv

// File: testbench/soc_bus_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module soc_bus_assertions (
    input logic                           sys_clk,
    input logic                           sys_rst,
    input logic                           inst_stb_i,
    input logic                           inst_ack_i,
    input logic                           inst_err_i,
    input logic [soc_bus_pkg::ADDR_W-1:0] data_adr_i,
    input logic                           data_cyc_i,
    input logic                           data_stb_i,
    input logic                           data_ack_i,
    input logic                           data_err_i,
    input logic                           sram_ce_n_i,
    input logic                           sram_oe_n_i,
    input logic                           sram_we_n_i,
    input logic                           sram_data_oe_i,
    input logic                           timer_irq_i
);
    import soc_bus_pkg::*;

    logic in_sram;
    logic in_clint;
    logic data_stb_q;     // Strobes one cycle back
    logic inst_stb_q;
    logic fresh_req;      // Data request on an idle bus, no fetch around
    int   fail_cnt = 0;   // Failed assertions so far

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            data_stb_q <= 1'b0;
            inst_stb_q <= 1'b0;
        end else begin
            data_stb_q <= data_stb_i;
            inst_stb_q <= inst_stb_i;
        end
    end

    assign in_sram   = (data_adr_i & SRAM_MASK) == SRAM_BASE;
    assign in_clint  = (data_adr_i & CLINT_MASK) == CLINT_BASE;
    assign fresh_req = data_cyc_i && data_stb_i && !data_stb_q
                     && !inst_stb_i && !inst_stb_q;

    // Everything quiet while reset is held
    reset_quiet: assert property (@(posedge sys_clk)
        sys_rst |-> !inst_ack_i && !inst_err_i && !data_ack_i && !data_err_i
                    && sram_ce_n_i && sram_oe_n_i && sram_we_n_i
                    && !sram_data_oe_i && !timer_irq_i)
        else begin
            $error("Outputs active during reset");
            fail_cnt++;
        end

    ack_err_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(inst_ack_i && inst_err_i) && !(data_ack_i && data_err_i))
        else begin
            $error("Ack and err high together");
            fail_cnt++;
        end

    sram_latency: assert property (@(posedge sys_clk) disable iff (sys_rst)
        fresh_req && in_sram |=> !data_ack_i ##1 data_ack_i)
        else begin
            $error("SRAM ack not two cycles after stb");
            fail_cnt++;
        end

    clint_latency: assert property (@(posedge sys_clk) disable iff (sys_rst)
        fresh_req && in_clint |=> data_ack_i)
        else begin
            $error("Timer ack not one cycle after stb");
            fail_cnt++;
        end

    unmapped_err: assert property (@(posedge sys_clk) disable iff (sys_rst)
        fresh_req && !in_sram && !in_clint |=> data_err_i && !data_ack_i)
        else begin
            $error("Unmapped access did not end in err");
            fail_cnt++;
        end

    // Chip stays deselected for an unmapped access
    unmapped_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
        data_stb_i && !in_sram && !in_clint && !inst_stb_i |-> sram_ce_n_i)
        else begin
            $error("SRAM selected by an unmapped access");
            fail_cnt++;
        end

    // Data pins driven exactly while the write strobe is low
    sram_drive: assert property (@(posedge sys_clk) disable iff (sys_rst)
        sram_data_oe_i == !sram_we_n_i)
        else begin
            $error("SRAM data output enable does not follow the write strobe");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: testbench/tb_soc_bus.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc_bus;
    import soc_bus_pkg::*;

    localparam int  CLK_PERIOD = 4;
    localparam int  NUM_TESTS  = 6;
    localparam int  MEM_WORDS  = 4096;
    localparam logic [ADDR_W-1:0] MTIME_LO = CLINT_BASE | {12'h0, MTIME_OFS};
    localparam logic [ADDR_W-1:0] CMP_LO   = CLINT_BASE | {12'h0, MTIMECMP_OFS};
    localparam logic [ADDR_W-1:0] BAD_ADR  = 32'h4000_0000;

    logic sys_clk;
    logic sys_rst;
    logic [ADDR_W-1:0]      inst_adr_i;
    logic                   inst_cyc_i;
    logic                   inst_stb_i;
    logic [DATA_W-1:0]      inst_dat_o;
    logic                   inst_ack_o;
    logic                   inst_err_o;
    logic [ADDR_W-1:0]      data_adr_i;
    logic [DATA_W-1:0]      data_dat_i;
    logic                   data_we_i;
    logic [SEL_W-1:0]       data_sel_i;
    logic                   data_cyc_i;
    logic                   data_stb_i;
    logic [DATA_W-1:0]      data_dat_o;
    logic                   data_ack_o;
    logic                   data_err_o;
    logic [SRAM_ADDR_W-1:0] sram_addr_o;
    logic [DATA_W-1:0]      sram_data_i;
    logic [DATA_W-1:0]      sram_data_o;
    logic                   sram_data_oe_o;
    logic                   sram_ce_n_o;
    logic                   sram_oe_n_o;
    logic                   sram_we_n_o;
    logic [SEL_W-1:0]       sram_be_n_o;
    logic                   timer_irq_o;

    logic [DATA_W-1:0] sram_mem [MEM_WORDS];  // Chip contents
    logic [DATA_W-1:0] shadow [8];            // Expected SRAM words
    int                errors;
    int                tests_failed;
    int                tests_run;
    int                asrt_seen;             // Assertion failures already counted
    logic [DATA_W-1:0] rd_a;
    logic [DATA_W-1:0] rd_b;
    logic              err_a;
    logic              err_b;
    time               t_a;
    time               t_b;

    soc_bus_top DUT (.*);

    bind soc_bus_top soc_bus_assertions u_assertions (
        .sys_clk(sys_clk), .sys_rst(sys_rst),
        .inst_stb_i(inst_stb_i), .inst_ack_i(inst_ack_o), .inst_err_i(inst_err_o),
        .data_adr_i(data_adr_i), .data_cyc_i(data_cyc_i), .data_stb_i(data_stb_i),
        .data_ack_i(data_ack_o), .data_err_i(data_err_o),
        .sram_ce_n_i(sram_ce_n_o), .sram_oe_n_i(sram_oe_n_o), .sram_we_n_i(sram_we_n_o),
        .sram_data_oe_i(sram_data_oe_o), .timer_irq_i(timer_irq_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // Preset pattern over the whole word index
    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        return {idx[15:0] ^ 16'h5A5A, ~idx[15:0]};
    endfunction

    function automatic logic [DATA_W-1:0] apply_sel(
        input logic [DATA_W-1:0] old_w, input logic [DATA_W-1:0] new_w,
        input logic [SEL_W-1:0] sel
    );
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // Chip model, read while oe_n low, write on the we_n rising edge
    assign sram_data_i = (!sram_ce_n_o && !sram_oe_n_o) ? sram_mem[sram_addr_o[11:0]] : '0;

    always @(posedge sram_we_n_o) begin
        if (!sys_rst) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (!sram_be_n_o[b]) begin
                    sram_mem[sram_addr_o[11:0]][8*b +: 8] = sram_data_o[8*b +: 8];
                end
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        // Protocol assertion failures count toward this test
        errors   += DUT.u_assertions.fail_cnt - asrt_seen;
        asrt_seen = DUT.u_assertions.fail_cnt;
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("Test %s: failed", name);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    // Data master, request held until ack or err
    task automatic data_access(
        input logic [ADDR_W-1:0] adr, input logic we, input logic [SEL_W-1:0] sel,
        input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat,
        output logic err, output time t_done
    );
        @(posedge sys_clk);
        data_adr_i <= adr;
        data_we_i  <= we;
        data_sel_i <= sel;
        data_dat_i <= wdat;
        data_cyc_i <= 1'b1;
        data_stb_i <= 1'b1;
        @(negedge sys_clk);
        while (!(data_ack_o || data_err_o)) @(negedge sys_clk);
        rdat   = data_dat_o;
        err    = data_err_o;
        t_done = $time;
        @(posedge sys_clk);
        data_cyc_i <= 1'b0;
        data_stb_i <= 1'b0;
        data_we_i  <= 1'b0;
    endtask

    task automatic fetch_read(
        input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdat,
        output logic err, output time t_done
    );
        @(posedge sys_clk);
        inst_adr_i <= adr;
        inst_cyc_i <= 1'b1;
        inst_stb_i <= 1'b1;
        @(negedge sys_clk);
        while (!(inst_ack_o || inst_err_o)) @(negedge sys_clk);
        rdat   = inst_dat_o;
        err    = inst_err_o;
        t_done = $time;
        @(posedge sys_clk);
        inst_cyc_i <= 1'b0;
        inst_stb_i <= 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] w);
        data_access(adr, 1'b1, 4'hF, w, rd_a, err_a, t_a);
    endtask

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("Watchdog expired, a transfer never finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int e0;
        int n;
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] cur;

        errors = 0;
        tests_failed = 0;
        tests_run = 0;
        asrt_seen = 0;
        void'($urandom(32'haef4));
        for (int i = 0; i < MEM_WORDS; i++) sram_mem[i] = fill_word(i);
        sys_rst    = 1'b1;
        inst_adr_i = '0;
        inst_cyc_i = 1'b0;
        inst_stb_i = 1'b0;
        data_adr_i = '0;
        data_dat_i = '0;
        data_we_i  = 1'b0;
        data_sel_i = '0;
        data_cyc_i = 1'b0;
        data_stb_i = 1'b0;

        // Status word all zero while reset is held
        e0 = errors;
        repeat (5) @(posedge sys_clk);
        @(negedge sys_clk);
        check_val("after_reset", 0, {inst_ack_o, inst_err_o, data_ack_o, data_err_o,
            ~sram_ce_n_o, ~sram_oe_n_o, ~sram_we_n_o, sram_data_oe_o, timer_irq_o});
        repeat (5) @(posedge sys_clk);
        sys_rst <= 1'b0;
        end_test("after_reset", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            shadow[i] = $urandom;
            write_word(SRAM_BASE + 32'(i * 4), shadow[i]);
        end
        for (int i = 0; i < 8; i++) begin
            data_access(SRAM_BASE + 32'(i * 4), 1'b0, 4'hF, '0, rd_a, err_a, t_a);
            check_val("sram_full_word", shadow[i], rd_a);
        end
        w = $urandom;
        data_access(SRAM_BASE, 1'b1, 4'b0101, w, rd_a, err_a, t_a);
        shadow[0] = apply_sel(shadow[0], w, 4'b0101);  // Bytes 1 and 3 kept
        data_access(SRAM_BASE, 1'b0, 4'hF, '0, rd_a, err_a, t_a);
        check_val("sram_partial", shadow[0], rd_a);
        end_test("sram_data_path", e0);

        e0 = errors;
        fork
            data_access(SRAM_BASE + 32'h8, 1'b0, 4'hF, '0, rd_a, err_a, t_a);
            fetch_read(SRAM_BASE + 32'h50, rd_b, err_b, t_b);
        join
        check_val("contention_data", shadow[2], rd_a);
        check_val("contention_fetch", fill_word(20), rd_b);
        check_val("contention_order", 1, t_a < t_b);
        end_test("contention", e0);

        e0 = errors;
        data_access(BAD_ADR, 1'b0, 4'hF, '0, rd_a, err_a, t_a);
        check_val("unmapped_read_err", 1, err_a);
        data_access(BAD_ADR + 32'h10, 1'b1, 4'hF, 32'hDEAD_BEEF, rd_a, err_a, t_a);
        check_val("unmapped_write_err", 1, err_a);
        fetch_read(BAD_ADR + 32'h20, rd_b, err_b, t_b);  // Fetch side err path
        check_val("unmapped_fetch_err", 1, err_b);
        end_test("unmapped", e0);

        e0 = errors;
        data_access(MTIME_LO, 1'b0, 4'hF, '0, rd_a, err_a, t_a);
        repeat (30) @(posedge sys_clk);
        data_access(MTIME_LO, 1'b0, 4'hF, '0, rd_b, err_b, t_b);
        check_val("mtime_increments", 1, rd_b > rd_a);
        write_word(MTIME_LO + 32'h4, 32'h0000_0012);
        write_word(MTIME_LO, 32'h1000_0000);
        data_access(MTIME_LO + 32'h4, 1'b0, 4'hF, '0, rd_a, err_a, t_a);
        data_access(MTIME_LO, 1'b0, 4'hF, '0, rd_b, err_b, t_b);
        check_val("mtime_hi", 32'h0000_0012, rd_a);
        check_val("mtime_lo_near", 1, rd_b > 32'h1000_0000 && rd_b < 32'h1000_0020);
        end_test("timer_count", e0);

        e0 = errors;
        data_access(MTIME_LO, 1'b0, 4'hF, '0, cur, err_a, t_a);
        write_word(CMP_LO, cur + 32'd200);  // Hi still all ones
        write_word(CMP_LO + 32'h4, 32'h0000_0012);
        @(negedge sys_clk);
        check_val("irq_low_before", 0, timer_irq_o);
        n = 0;
        while (!timer_irq_o && n < 1000) begin
            @(negedge sys_clk);
            n++;
        end
        check_val("irq_delay", 1, n >= 150 && n <= 210);
        write_word(CMP_LO, 32'hFFFF_FFFF);
        write_word(CMP_LO + 32'h4, 32'hFFFF_FFFF);
        repeat (3) @(negedge sys_clk);
        check_val("irq_dropped", 0, timer_irq_o);
        end_test("timer_irq", e0);

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
